// ==== common/exec_if.sv ====
/*
 * Execute handoff
 * Carries an instruction with its fetched operands from issue to the ALU
 */
`timescale 1ns/1ps

interface exec_if;
	import strand_isa_pkg::*;
	import strand_pipe_pkg::*;

	// Instruction in the read slot, driven by issue
	logic     valid;
	strand_t  strand;
	opcode_e  op;
	reg_idx_t dst;
	imm_t     imm;

	// Operands as returned by the register file
	word_t    src1_value;
	word_t    src2_value;

	// ALU stage can take the instruction this cycle
	logic     ready;

	modport fetch (
		output valid, strand, op, dst, imm, src1_value, src2_value,
		input  ready
	);

	modport exec (
		input  valid, strand, op, dst, imm, src1_value, src2_value,
		output ready
	);

endinterface

// ==== common/strand_core_macros.svh ====
/*
 * Strand core sizing
 * Strand count, register count and data widths shared by the packages and storage
 */
`ifndef STRAND_CORE_MACROS_SVH
`define STRAND_CORE_MACROS_SVH

// Hardware strands sharing one execution slice
`define STRANDS_PER_CORE 4

// Architectural scalar registers seen by each strand
`define REGS_PER_STRAND 32

// Width of a data word in the register file and ALU
`define WORD_WIDTH 32

// Width of the immediate field, zero-extended by load-immediate
`define IMM_WIDTH 16

`endif

// ==== common/strand_isa_pkg.sv ====
/*
 * Instruction-set types
 * Data word, immediate, register number and the scalar opcode set
 */
`include "strand_core_macros.svh"

package strand_isa_pkg;

	// One data word as held in a register
	typedef logic [`WORD_WIDTH-1:0] word_t;

	// Immediate operand, only used by load-immediate
	typedef logic [`IMM_WIDTH-1:0] imm_t;

	// Register number as the program sees it, local to one strand
	typedef logic [$clog2(`REGS_PER_STRAND)-1:0] reg_idx_t;

	// Scalar operations executed by the ALU stage
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_shl = 3'd5,
		op_shr = 3'd6,
		op_li  = 3'd7
	} opcode_e;

endpackage

// ==== common/strand_pipe_pkg.sv ====
/*
 * Microarchitecture types
 * Strand identifiers and the strand-qualified physical register index
 */
`include "strand_core_macros.svh"

package strand_pipe_pkg;

	// Hardware strand number
	typedef logic [$clog2(`STRANDS_PER_CORE)-1:0] strand_t;

	// Index into the whole register file
	// Upper bits are the strand, lower bits the register number
	typedef logic [$clog2(`STRANDS_PER_CORE * `REGS_PER_STRAND)-1:0] phys_reg_t;

endpackage

// ==== dv/result_checker.sv ====
/*
 * Result checker
 * Compares every output handshake with the oldest expected result and keeps per-test scores
 */
`timescale 1ns/1ps
`include "strand_core_macros.svh"

module result_checker (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_ready,
	input  logic                                  out_valid,
	input  logic                                  out_ready,
	input  logic [$clog2(`STRANDS_PER_CORE)-1:0]  out_strand,
	input  strand_isa_pkg::reg_idx_t              out_dst,
	input  strand_isa_pkg::word_t                 out_value
);
	import strand_isa_pkg::*;

	typedef struct packed {
		logic [31:0]                          test_id;
		logic [$clog2(`STRANDS_PER_CORE)-1:0] strand;
		reg_idx_t                             dst;
		word_t                                value;
	} expected_t;

	// Results still owed by the DUT with the oldest at the front
	expected_t   expected_q [$];
	int          checked = 0;
	int          errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          cur_errors = 0;
	logic [31:0] cur_test = 32'd1;
	logic        reset_done = 1'b0;

	// Called by the driver for each instruction it offers
	task automatic expect_result(input logic [31:0] test_id,
		input logic [$clog2(`STRANDS_PER_CORE)-1:0] strand, input reg_idx_t dst,
		input word_t value);
		expected_t entry;
		entry.test_id = test_id;
		entry.strand  = strand;
		entry.dst     = dst;
		entry.value   = value;
		expected_q.push_back(entry);
	endtask

	task automatic note_error();
		errors++;
		cur_errors++;
	endtask

	// Print the verdict of the test that just ended
	task automatic close_test();
		if (cur_errors == 0)
		begin
			tests_passed++;
			$display("Test %0d passed", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("Test %0d failed with %0d errors", cur_test, cur_errors);
		end
		cur_errors = 0;
	endtask

	task automatic check_result();
		expected_t exp;
		if (expected_q.size() == 0)
		begin
			$display("Output handshake on strand %0d register %0d with no result outstanding",
				out_strand, out_dst);
			note_error();
			return;
		end
		exp = expected_q.pop_front();
		// A new test id means the previous test has delivered all its results
		if (exp.test_id != cur_test)
		begin
			if (cur_test != 0)
				close_test();
			cur_test = exp.test_id;
		end
		if (out_strand !== exp.strand)
		begin
			$display("[ERROR] test %0d out_strand expected 0x%h got 0x%h",
				cur_test, exp.strand, out_strand);
			note_error();
		end
		if (out_dst !== exp.dst)
		begin
			$display("[ERROR] test %0d out_dst expected 0x%h got 0x%h",
				cur_test, exp.dst, out_dst);
			note_error();
		end
		if (out_value !== exp.value)
		begin
			$display("[ERROR] test %0d out_value expected 0x%h got 0x%h",
				cur_test, exp.value, out_value);
			note_error();
		end
		checked++;
	endtask

	// Test 1 covers the cycles in reset and the first edge after release
	// Both handshake sides stay closed until issue has seen one clean edge
	always @(posedge clk)
	begin
		if (!reset_done)
		begin
			if (out_valid !== 1'b0)
			begin
				$display("[ERROR] test 1 out_valid expected 0x0 got 0x%h", out_valid);
				note_error();
			end
			if (in_ready !== 1'b0)
			begin
				$display("[ERROR] test 1 in_ready expected 0x0 got 0x%h", in_ready);
				note_error();
			end
			if (rst_n)
			begin
				reset_done = 1'b1;
				close_test();
				cur_test = 32'd0;
			end
		end
		else if (out_valid && out_ready)
			check_result();
	end

	// Closes the last test and prints the totals
	task automatic finish_report();
		if (cur_test != 0)
			close_test();
		$display("Tests passed %0d, failed %0d, results checked %0d, errors %0d",
			tests_passed, tests_failed, checked, errors);
	endtask

endmodule

// ==== dv/strand_core_input.txt ====
// Columns in hex: test strand op dst src1 src2 imm expected, result returns on strand/dst
// Opcodes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 shl, 6 shr, 7 li
02 0 7 01 00 00 1234 00001234
02 0 7 02 00 00 ffff 0000ffff
02 0 7 03 00 00 0001 00000001
02 0 7 04 00 00 0023 00000023
02 0 7 05 00 00 001f 0000001f
03 0 0 06 02 03 0000 00010000
03 0 5 07 02 05 0000 80000000
03 0 0 08 07 07 0000 00000000
03 0 1 09 03 02 0000 ffff0002
03 0 2 0a 01 02 0000 00001234
03 0 3 0b 01 09 0000 ffff1236
03 0 4 0c 01 02 0000 0000edcb
03 0 5 0d 01 04 0000 000091a0
03 0 6 0e 07 04 0000 10000000
04 1 7 01 00 00 0005 00000005
04 1 0 01 01 01 0000 0000000a
04 1 5 02 01 01 0000 00002800
05 2 7 03 00 00 aaaa 0000aaaa
05 3 7 03 00 00 5555 00005555
05 2 3 10 03 03 0000 0000aaaa
05 3 3 10 03 03 0000 00005555
05 0 3 10 03 03 0000 00000001
06 3 7 04 00 00 0011 00000011
06 3 7 05 00 00 0022 00000022
06 3 4 06 04 05 0000 00000033
06 2 7 04 00 00 0044 00000044

// ==== dv/strand_core_tb.sv ====
/*
 * Strand core testbench
 * Replays the instruction file on falling edges with LFSR output back-pressure
 */
`timescale 1ns/1ps
`include "strand_core_macros.svh"

module tb_clock_gen (
	output logic clk
);
	// Free-running clock with a 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end
endmodule

module strand_core_tb;
	import strand_isa_pkg::*;

	localparam int STRAND_W  = $clog2(`STRANDS_PER_CORE);
	localparam int MAX_ROWS  = 64;
	localparam int ROW_WORDS = 8;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	logic [STRAND_W-1:0] in_strand;
	opcode_e             in_op;
	reg_idx_t            in_dst;
	reg_idx_t            in_src1;
	reg_idx_t            in_src2;
	imm_t                in_imm;
	logic                in_ready;
	logic                out_valid;
	logic [STRAND_W-1:0] out_strand;
	reg_idx_t            out_dst;
	word_t               out_value;
	logic                out_ready;

	// Eight words per instruction line with an all-zero test id after the last one
	logic [31:0] stim_mem [0:MAX_ROWS*ROW_WORDS-1];
	logic [7:0]  lfsr_state;
	int          num_rows = 0;
	int          timeout_limit = 0;
	int          cycle_count = 0;
	int          idx;

	tb_clock_gen clk_gen_i (.clk(clk));

	strand_core_top dut_i (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_strand(in_strand), .in_op(in_op), .in_dst(in_dst),
		.in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm), .in_ready(in_ready),
		.out_valid(out_valid), .out_strand(out_strand), .out_dst(out_dst),
		.out_value(out_value), .out_ready(out_ready)
	);

	result_checker checker_i (
		.clk(clk), .rst_n(rst_n), .in_ready(in_ready),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_strand(out_strand), .out_dst(out_dst), .out_value(out_value)
	);

	// Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic feedback;
		feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], feedback};
	endfunction

	// Offer one line of the file and hold it until issue takes it
	task automatic send_instruction(input int row);
		int base;
		base = row * ROW_WORDS;
		checker_i.expect_result(stim_mem[base], stim_mem[base + 1][STRAND_W-1:0],
			stim_mem[base + 3][4:0], stim_mem[base + 7]);
		@(negedge clk);
		in_valid  = 1'b1;
		in_strand = stim_mem[base + 1][STRAND_W-1:0];
		in_op     = opcode_e'(stim_mem[base + 2][2:0]);
		in_dst    = stim_mem[base + 3][4:0];
		in_src1   = stim_mem[base + 4][4:0];
		in_src2   = stim_mem[base + 5][4:0];
		in_imm    = stim_mem[base + 6][15:0];
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
	endtask

	// Output back-pressure with one LFSR step per ready bit
	initial
	begin
		lfsr_state = 8'd74;
		out_ready  = 1'b0;
		@(posedge rst_n);
		forever
		begin
			@(negedge clk);
			lfsr_state = lfsr_next(lfsr_state);
			out_ready  = lfsr_state[0];
		end
	end

	initial
	begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_strand = '0;
		in_op     = op_add;
		in_dst    = '0;
		in_src1   = '0;
		in_src2   = '0;
		in_imm    = '0;
		for (idx = 0; idx < MAX_ROWS * ROW_WORDS; idx++)
			stim_mem[idx] = '0;
		$readmemh("dv/strand_core_input.txt", stim_mem);
		while (num_rows < MAX_ROWS && stim_mem[num_rows * ROW_WORDS] != 0)
			num_rows++;
		timeout_limit = num_rows * 8 + 100;
		if (num_rows == 0)
			$display("The input file held no instructions");

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (idx = 0; idx < num_rows; idx++)
			send_instruction(idx);
		@(negedge clk);
		in_valid = 1'b0;

		// Wait for every result and a few idle edges more to catch stray handshakes
		while (checker_i.checked < num_rows)
			@(posedge clk);
		repeat (4) @(posedge clk);
		checker_i.finish_report();
		if (checker_i.errors == 0 && num_rows > 0 && checker_i.checked == num_rows)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Cycle limit scales with the number of instructions in the file
	initial
	begin
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles with %0d of %0d results seen",
			cycle_count, checker_i.checked, num_rows);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== logic/alu_stage.sv ====
/*
 * ALU stage
 * Computes the scalar result and holds it in a one-entry stage register
 */
`timescale 1ns/1ps

module alu_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	exec_if.exec                     exec,
	output logic                     res_valid,
	output strand_pipe_pkg::strand_t res_strand,
	output strand_isa_pkg::reg_idx_t res_dst,
	output strand_isa_pkg::word_t    res_value,
	input  logic                     res_ready
);
	import strand_isa_pkg::*;

	word_t result;
	logic  take;

	// Shift amounts use only the low five bits of the second operand
	always_comb
	begin
		case (exec.op)
			op_add:  result = exec.src1_value + exec.src2_value;
			op_sub:  result = exec.src1_value - exec.src2_value;
			op_and:  result = exec.src1_value & exec.src2_value;
			op_or:   result = exec.src1_value | exec.src2_value;
			op_xor:  result = exec.src1_value ^ exec.src2_value;
			op_shl:  result = exec.src1_value << exec.src2_value[4:0];
			op_shr:  result = exec.src1_value >> exec.src2_value[4:0];
			op_li:   result = word_t'(exec.imm);
			default: result = '0;
		endcase
	end

	// Stage takes a new result when empty or when the current one leaves
	assign exec.ready = !res_valid || res_ready;
	assign take       = exec.valid && exec.ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else if (take)
			res_valid <= 1'b1;
		else if (res_ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			res_strand <= exec.strand;
			res_dst    <= exec.dst;
			res_value  <= result;
		end
	end

endmodule

// ==== logic/issue_scoreboard.sv ====
/*
 * Issue stage with scoreboard
 * Accepts hazard-free instructions, drives the register reads and offers them to the ALU
 */
`timescale 1ns/1ps

module issue_scoreboard (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_valid,
	input  strand_pipe_pkg::strand_t   in_strand,
	input  strand_isa_pkg::opcode_e    in_op,
	input  strand_isa_pkg::reg_idx_t   in_dst,
	input  strand_isa_pkg::reg_idx_t   in_src1,
	input  strand_isa_pkg::reg_idx_t   in_src2,
	input  strand_isa_pkg::imm_t       in_imm,
	output logic                       in_ready,
	output strand_pipe_pkg::phys_reg_t sel1,
	output strand_pipe_pkg::phys_reg_t sel2,
	input  strand_isa_pkg::word_t      value1,
	input  strand_isa_pkg::word_t      value2,
	input  logic                       wb_enable,
	input  strand_pipe_pkg::phys_reg_t wb_reg,
	input  strand_isa_pkg::word_t      wb_value,
	exec_if.fetch                      fetch
);
	import strand_isa_pkg::*;
	import strand_pipe_pkg::*;

	localparam int NUM_PHYS = 2 ** $bits(phys_reg_t);

	// One bit per physical register with a write still in flight
	logic [NUM_PHYS-1:0] pending;
	logic                started;
	logic                slot_valid;
	logic                slot_free;
	logic                hazard;
	logic                accept;
	logic                src1_wake;
	logic                src2_wake;
	strand_t             slot_strand;
	opcode_e             slot_op;
	reg_idx_t            slot_dst;
	imm_t                slot_imm;
	phys_reg_t           slot_src1;
	phys_reg_t           slot_src2;
	phys_reg_t           in_src1_reg;
	phys_reg_t           in_src2_reg;
	phys_reg_t           in_dst_reg;

	assign in_src1_reg = {in_strand, in_src1};
	assign in_src2_reg = {in_strand, in_src2};
	assign in_dst_reg  = {in_strand, in_dst};

	// A source whose write completes this cycle counts as ready
	assign src1_wake = wb_enable && (wb_reg == in_src1_reg);
	assign src2_wake = wb_enable && (wb_reg == in_src2_reg);

	// Load-immediate has no sources while every other op reads both
	always_comb
	begin
		hazard = pending[in_dst_reg] && !(wb_enable && (wb_reg == in_dst_reg));
		if (in_op != op_li)
			hazard = hazard || (pending[in_src1_reg] && !src1_wake)
				|| (pending[in_src2_reg] && !src2_wake);
	end

	// The read slot can take a new instruction if it is empty or moving on to the ALU
	assign slot_free = !slot_valid || fetch.ready;
	assign in_ready  = started && slot_free && !hazard;
	assign accept    = in_valid && in_ready;

	// While the slot is held, keep reading its sources so the data stays put
	assign sel1 = slot_free ? in_src1_reg : slot_src1;
	assign sel2 = slot_free ? in_src2_reg : slot_src2;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			started    <= 1'b0;
			slot_valid <= 1'b0;
			pending    <= '0;
		end
		else
		begin
			// Issue stays closed for the first cycle out of reset
			started <= 1'b1;
			if (accept)
				slot_valid <= 1'b1;
			else if (fetch.ready)
				slot_valid <= 1'b0;

			// Clear before set so a new write to the same register wins
			if (wb_enable)
				pending[wb_reg] <= 1'b0;
			if (accept)
				pending[in_dst_reg] <= 1'b1;
		end
	end

	// Payload of the read slot is captured on accept
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			slot_strand <= in_strand;
			slot_op     <= in_op;
			slot_dst    <= in_dst;
			slot_imm    <= in_imm;
			slot_src1   <= in_src1_reg;
			slot_src2   <= in_src2_reg;
		end
	end

	assign fetch.valid  = slot_valid;
	assign fetch.strand = slot_strand;
	assign fetch.op     = slot_op;
	assign fetch.dst    = slot_dst;
	assign fetch.imm    = slot_imm;

	// The register file already returns a same-cycle write on its read ports
	assign fetch.src1_value = value1;
	assign fetch.src2_value = value2;

endmodule

// ==== logic/result_writeback.sv ====
/*
 * Result writeback
 * Output register that commits to the register file on the output handshake
 */
`timescale 1ns/1ps

module result_writeback (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       res_valid,
	input  strand_pipe_pkg::strand_t   res_strand,
	input  strand_isa_pkg::reg_idx_t   res_dst,
	input  strand_isa_pkg::word_t      res_value,
	output logic                       res_ready,
	output logic                       out_valid,
	output strand_pipe_pkg::strand_t   out_strand,
	output strand_isa_pkg::reg_idx_t   out_dst,
	output strand_isa_pkg::word_t      out_value,
	input  logic                       out_ready,
	output logic                       wb_enable,
	output strand_pipe_pkg::phys_reg_t wb_reg,
	output strand_isa_pkg::word_t      wb_value
);
	assign res_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (res_valid && res_ready)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (res_valid && res_ready)
		begin
			out_strand <= res_strand;
			out_dst    <= res_dst;
			out_value  <= res_value;
		end
	end

	// The architectural write lands on the same edge the consumer takes the result
	assign wb_enable = out_valid && out_ready;
	assign wb_reg    = {out_strand, out_dst};
	assign wb_value  = out_value;

endmodule

// ==== logic/strand_core_top.sv ====
/*
 * Strand core execution slice
 * Issue, register read, ALU and writeback for four hardware strands
 */
`timescale 1ns/1ps

module strand_core_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  strand_pipe_pkg::strand_t in_strand,
	input  strand_isa_pkg::opcode_e  in_op,
	input  strand_isa_pkg::reg_idx_t in_dst,
	input  strand_isa_pkg::reg_idx_t in_src1,
	input  strand_isa_pkg::reg_idx_t in_src2,
	input  strand_isa_pkg::imm_t     in_imm,
	output logic                     in_ready,
	output logic                     out_valid,
	output strand_pipe_pkg::strand_t out_strand,
	output strand_isa_pkg::reg_idx_t out_dst,
	output strand_isa_pkg::word_t    out_value,
	input  logic                     out_ready
);
	import strand_isa_pkg::*;
	import strand_pipe_pkg::*;

	phys_reg_t sel1;
	phys_reg_t sel2;
	word_t     value1;
	word_t     value2;
	logic      wb_enable;
	phys_reg_t wb_reg;
	word_t     wb_value;
	logic      res_valid;
	strand_t   res_strand;
	reg_idx_t  res_dst;
	word_t     res_value;
	logic      res_ready;

	// Read slot to ALU handoff
	exec_if ex_bus ();

	issue_scoreboard issue_i (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_strand(in_strand), .in_op(in_op), .in_dst(in_dst),
		.in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm), .in_ready(in_ready),
		.sel1(sel1), .sel2(sel2), .value1(value1), .value2(value2),
		.wb_enable(wb_enable), .wb_reg(wb_reg), .wb_value(wb_value),
		.fetch(ex_bus.fetch)
	);

	scalar_register_file regfile_i (
		.clk(clk), .sel1(sel1), .sel2(sel2), .value1(value1), .value2(value2),
		.wb_enable(wb_enable), .wb_reg(wb_reg), .wb_value(wb_value)
	);

	alu_stage alu_i (
		.clk(clk), .rst_n(rst_n), .exec(ex_bus.exec),
		.res_valid(res_valid), .res_strand(res_strand), .res_dst(res_dst),
		.res_value(res_value), .res_ready(res_ready)
	);

	result_writeback wb_i (
		.clk(clk), .rst_n(rst_n),
		.res_valid(res_valid), .res_strand(res_strand), .res_dst(res_dst),
		.res_value(res_value), .res_ready(res_ready),
		.out_valid(out_valid), .out_strand(out_strand), .out_dst(out_dst),
		.out_value(out_value), .out_ready(out_ready),
		.wb_enable(wb_enable), .wb_reg(wb_reg), .wb_value(wb_value)
	);

endmodule

// ==== register_file/scalar_register_file.sv ====
/*
 * Scalar register file
 * Registers for all strands, two synchronous read ports and one write port
 */
`timescale 1ns/1ps
`include "strand_core_macros.svh"

module scalar_register_file (
	input  logic                       clk,
	input  strand_pipe_pkg::phys_reg_t sel1,
	input  strand_pipe_pkg::phys_reg_t sel2,
	output strand_isa_pkg::word_t      value1,
	output strand_isa_pkg::word_t      value2,
	input  logic                       wb_enable,
	input  strand_pipe_pkg::phys_reg_t wb_reg,
	input  strand_isa_pkg::word_t      wb_value
);
	import strand_isa_pkg::*;

	localparam int TOTAL_REGS = `STRANDS_PER_CORE * `REGS_PER_STRAND;

	// Contents are undefined until the first write to each register
	word_t registers [0:TOTAL_REGS-1];

	// Registered read ports return data the cycle after the select
	// A read of the register being written returns the incoming value
	always_ff @(posedge clk)
	begin
		if (wb_enable && (sel1 == wb_reg))
			value1 <= wb_value;
		else
			value1 <= registers[sel1];

		if (wb_enable && (sel2 == wb_reg))
			value2 <= wb_value;
		else
			value2 <= registers[sel2];
	end

	// Single write port fed by writeback
	always_ff @(posedge clk)
	begin
		if (wb_enable)
			registers[wb_reg] <= wb_value;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the strand core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module strand_core_tb \
	-f strand_core.f -o strand_core_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/strand_core_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== strand_core.f ====
+incdir+common
common/strand_isa_pkg.sv
common/strand_pipe_pkg.sv
common/exec_if.sv
register_file/scalar_register_file.sv
logic/issue_scoreboard.sv
logic/alu_stage.sv
logic/result_writeback.sv
logic/strand_core_top.sv
dv/result_checker.sv
dv/strand_core_tb.sv
